/* rtl/alu_config.svh */
// Size macros for the scalar ALU execute block
// Data path, warp, tag, queue, credit and multiplier sizes

`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Data path and warp sizing
`define ALU_XLEN            32
`define ALU_NUM_WARPS       4
`define ALU_WID_BITS        2
`define ALU_UUID_BITS       8

// Flow control and pipeline depths
`define ALU_QUEUE_DEPTH     4
`define ALU_COMMIT_CREDITS  2
`define ALU_MUL_LATENCY     2

`endif

/* rtl/alu_pkg.sv */
// Shared types of the ALU execute block
// Opcode enum, execute and commit structs, divider state enum

`include "alu_config.svh"

package alu_pkg;

    // Opcode classes: integer, branch, then multiply/divide
    typedef enum logic [4:0] {
        ADD   = 5'd0,
        SUB   = 5'd1,
        AND   = 5'd2,
        OR    = 5'd3,
        XOR   = 5'd4,
        SLL   = 5'd5,
        SRL   = 5'd6,
        SRA   = 5'd7,
        SLT   = 5'd8,
        SLTU  = 5'd9,
        BEQ   = 5'd10,
        BNE   = 5'd11,
        BLTU  = 5'd12,
        MUL   = 5'd13,
        MULHU = 5'd14,
        DIVU  = 5'd15,
        REMU  = 5'd16
    } alu_op_e;

    typedef struct packed {
        logic [`ALU_UUID_BITS-1:0] uuid;
        logic [`ALU_WID_BITS-1:0]  wid;
        alu_op_e                   op;
        logic [`ALU_XLEN-1:0]      pc;
        logic [`ALU_XLEN-1:0]      rs1_data;
        logic [`ALU_XLEN-1:0]      rs2_data;
        logic [`ALU_XLEN-1:0]      imm;
        logic [4:0]                rd;
        logic                      wb;
    } execute_t;

    typedef struct packed {
        logic [`ALU_UUID_BITS-1:0] uuid;
        logic [`ALU_WID_BITS-1:0]  wid;
        logic [4:0]                rd;
        logic                      wb;
        logic [`ALU_XLEN-1:0]      data;
    } commit_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

endpackage

/* rtl/alu_ifs.sv */
// Handshake interfaces between the execute blocks
// execute_if carries instructions, commit_if carries results

`timescale 1ns/10ps

// Instruction path from the dispatch queue to a unit
interface execute_if import alu_pkg::*; ();

    logic     valid;
    logic     ready;
    execute_t data;

    modport master (
        output valid,
        output data,
        input  ready
    );

    modport slave (
        input  valid,
        input  data,
        output ready
    );

endinterface

// Result path from a unit to the commit arbiter
interface commit_if import alu_pkg::*; ();

    logic    valid;
    logic    ready;
    commit_t data;

    modport master (
        output valid,
        output data,
        input  ready
    );

    modport slave (
        input  valid,
        input  data,
        output ready
    );

endinterface

/* rtl/dispatch_queue.sv */
// Dispatch queue of the ALU execute block
// Credited input FIFO that steers its head to the integer or mul/div unit

`timescale 1ns/10ps
`include "alu_config.svh"

module dispatch_queue import alu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      issue_valid,
    input  execute_t  issue_data,
    output logic      issue_credit,
    execute_if.master int_if,
    execute_if.master mdv_if
);

    localparam int PTR_BITS = $clog2(`ALU_QUEUE_DEPTH);

    execute_t            entries [`ALU_QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                head_valid;
    logic                head_is_mdv;
    logic                pop;

    assign head_valid  = (count != '0);
    assign head_is_mdv = entries[rd_ptr].op inside {MUL, MULHU, DIVU, REMU};

    // Only the unit matching the head opcode class sees a valid
    assign int_if.valid = head_valid && !head_is_mdv;
    assign mdv_if.valid = head_valid && head_is_mdv;
    assign int_if.data  = entries[rd_ptr];
    assign mdv_if.data  = entries[rd_ptr];

    assign pop          = (int_if.valid && int_if.ready) || (mdv_if.valid && mdv_if.ready);
    assign issue_credit = pop;

    // The source never writes without a credit, so a write always has room
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (issue_valid)
                wr_ptr <= wr_ptr + PTR_BITS'(1);
            if (pop)
                rd_ptr <= rd_ptr + PTR_BITS'(1);
            case ({issue_valid, pop})
                2'b10:   count <= count + (PTR_BITS + 1)'(1);
                2'b01:   count <= count - (PTR_BITS + 1)'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid)
            entries[wr_ptr] <= issue_data;
    end

endmodule

/* rtl/int_unit.sv */
// Integer and branch unit
// One combinational stage into a registered commit output and branch port

`timescale 1ns/10ps
`include "alu_config.svh"

module int_unit import alu_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    execute_if.slave                 execute,
    commit_if.master                 commit,
    output logic                     branch_valid,
    output logic [`ALU_WID_BITS-1:0] branch_wid,
    output logic                     branch_taken,
    output logic [`ALU_XLEN-1:0]     branch_target
);

    localparam int XLEN = `ALU_XLEN;

    execute_t        req;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] pc_next;
    logic [4:0]      shamt;
    logic            is_branch;
    logic            taken;
    logic            accept;
    logic            out_valid;
    commit_t         out_data;

    assign req     = execute.data;
    assign shamt   = req.rs2_data[4:0];
    assign pc_next = req.pc + XLEN'(4);

    always_comb begin
        result    = '0;
        is_branch = 1'b0;
        taken     = 1'b0;
        case (req.op)
            ADD:  result = req.rs1_data + req.rs2_data;
            SUB:  result = req.rs1_data - req.rs2_data;
            AND:  result = req.rs1_data & req.rs2_data;
            OR:   result = req.rs1_data | req.rs2_data;
            XOR:  result = req.rs1_data ^ req.rs2_data;
            SLL:  result = req.rs1_data << shamt;
            SRL:  result = req.rs1_data >> shamt;
            SRA:  result = $unsigned($signed(req.rs1_data) >>> shamt);
            SLT:  result = XLEN'($signed(req.rs1_data) < $signed(req.rs2_data));
            SLTU: result = XLEN'(req.rs1_data < req.rs2_data);
            // Branches write back the link address
            BEQ, BNE, BLTU: begin
                is_branch = 1'b1;
                result    = pc_next;
                case (req.op)
                    BEQ:     taken = (req.rs1_data == req.rs2_data);
                    BNE:     taken = (req.rs1_data != req.rs2_data);
                    default: taken = (req.rs1_data < req.rs2_data);
                endcase
            end
            default: result = '0;
        endcase
    end

    // A new instruction may enter while the held result leaves
    assign execute.ready = !out_valid || commit.ready;
    assign accept        = execute.valid && execute.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid    <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            if (accept)
                out_valid <= 1'b1;
            else if (commit.ready)
                out_valid <= 1'b0;
            branch_valid <= accept && is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data      <= '{uuid: req.uuid, wid: req.wid, rd: req.rd, wb: req.wb,
                               data: result};
            branch_wid    <= req.wid;
            branch_taken  <= taken;
            branch_target <= taken ? req.pc + req.imm : pc_next;
        end
    end

    assign commit.valid = out_valid;
    assign commit.data  = out_data;

endmodule

/* rtl/muldiv_unit.sv */
// Multiply and divide unit
// Pipelined unsigned multiplier, restoring divider, shared output register

`timescale 1ns/10ps
`include "alu_config.svh"

module muldiv_unit import alu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    execute_if.slave execute,
    commit_if.master commit
);

    localparam int XLEN     = `ALU_XLEN;
    localparam int PROD     = 2 * XLEN;
    localparam int CNT_BITS = $clog2(XLEN);
    // The output register is the last multiply stage
    localparam int PIPE_STAGES = `ALU_MUL_LATENCY - 1;

    execute_t               req;
    logic                   is_div;
    logic                   advance;
    logic                   accept;
    logic [PROD-1:0]        product;
    commit_t                mul_entry;
    logic [PIPE_STAGES-1:0] pipe_valid;
    commit_t                pipe_data [PIPE_STAGES];
    div_state_e             div_state;
    logic [XLEN-1:0]        div_rem;
    logic [XLEN-1:0]        div_quo;
    logic [XLEN-1:0]        div_divisor;
    logic [CNT_BITS-1:0]    div_count;
    logic                   div_is_rem;
    commit_t                div_tag;
    logic [XLEN:0]          div_shift;
    logic [XLEN:0]          div_diff;
    logic                   out_valid;
    commit_t                out_data;

    assign req     = execute.data;
    assign is_div  = req.op inside {DIVU, REMU};
    assign advance = !out_valid || commit.ready;

    // A divide waits for the multiply pipeline to drain so the two never meet
    assign execute.ready = advance && (div_state == IDLE) && !(is_div && (|pipe_valid));
    assign accept        = execute.valid && execute.ready;

    assign product   = PROD'(req.rs1_data) * PROD'(req.rs2_data);
    assign mul_entry = '{uuid: req.uuid, wid: req.wid, rd: req.rd, wb: req.wb,
                         data: (req.op == MULHU) ? product[PROD-1:XLEN] : product[XLEN-1:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_valid <= '0;
            out_valid  <= 1'b0;
        end else if (advance) begin
            for (int i = PIPE_STAGES - 1; i > 0; i--)
                pipe_valid[i] <= pipe_valid[i-1];
            pipe_valid[0] <= accept && !is_div;
            out_valid     <= pipe_valid[PIPE_STAGES-1] || (div_state == DONE);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = PIPE_STAGES - 1; i > 0; i--)
                pipe_data[i] <= pipe_data[i-1];
            pipe_data[0] <= mul_entry;
            if (pipe_valid[PIPE_STAGES-1])
                out_data <= pipe_data[PIPE_STAGES-1];
            else
                out_data <= '{uuid: div_tag.uuid, wid: div_tag.wid, rd: div_tag.rd,
                              wb: div_tag.wb, data: div_is_rem ? div_rem : div_quo};
        end
    end

    // One quotient bit per cycle; a zero divisor yields all ones and rs1
    assign div_shift = {div_rem, div_quo[XLEN-1]};
    assign div_diff  = div_shift - {1'b0, div_divisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            div_state <= IDLE;
        end else begin
            case (div_state)
                IDLE:    if (accept && is_div) div_state <= RUN;
                RUN:     if (div_count == '0) div_state <= DONE;
                DONE:    if (advance && !pipe_valid[PIPE_STAGES-1]) div_state <= IDLE;
                default: div_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_div) begin
            div_rem     <= '0;
            div_quo     <= req.rs1_data;
            div_divisor <= req.rs2_data;
            div_count   <= CNT_BITS'(XLEN - 1);
            div_is_rem  <= (req.op == REMU);
            div_tag     <= '{uuid: req.uuid, wid: req.wid, rd: req.rd, wb: req.wb, data: '0};
        end else if (div_state == RUN) begin
            div_count <= div_count - CNT_BITS'(1);
            if (!div_diff[XLEN]) begin
                div_rem <= div_diff[XLEN-1:0];
                div_quo <= {div_quo[XLEN-2:0], 1'b1};
            end else begin
                div_rem <= div_shift[XLEN-1:0];
                div_quo <= {div_quo[XLEN-2:0], 1'b0};
            end
        end
    end

    assign commit.valid = out_valid;
    assign commit.data  = out_data;

endmodule

/* rtl/commit_arb.sv */
// Commit arbiter
// Round-robin merge of two result streams onto one credited commit port

`timescale 1ns/10ps
`include "alu_config.svh"

module commit_arb import alu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    commit_if.slave int_in,
    commit_if.slave mdv_in,
    input  logic    commit_credit,
    output logic    commit_valid,
    output commit_t commit_data
);

    localparam int CREDIT_BITS = $clog2(`ALU_COMMIT_CREDITS + 1);

    logic [CREDIT_BITS-1:0] credits;
    logic                   can_accept;
    logic                   grant_int;
    logic                   grant_mdv;
    logic                   last_mdv;

    // Output register must be empty and a receiver slot must be free
    assign can_accept = !commit_valid && (credits != '0);

    // The mul/div side yields when it won last and the integer side waits
    assign grant_mdv = can_accept && mdv_in.valid && (!int_in.valid || !last_mdv);
    assign grant_int = can_accept && int_in.valid && !grant_mdv;

    assign int_in.ready = grant_int;
    assign mdv_in.ready = grant_mdv;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits      <= CREDIT_BITS'(`ALU_COMMIT_CREDITS);
            commit_valid <= 1'b0;
            last_mdv     <= 1'b0;
        end else begin
            commit_valid <= grant_int || grant_mdv;
            if (grant_int || grant_mdv)
                last_mdv <= grant_mdv;
            case ({commit_valid, commit_credit})
                2'b10:   credits <= credits - CREDIT_BITS'(1);
                2'b01:   credits <= credits + CREDIT_BITS'(1);
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant_mdv)
            commit_data <= mdv_in.data;
        else if (grant_int)
            commit_data <= int_in.data;
    end

endmodule

/* rtl/alu_unit.sv */
// Top level of the scalar ALU execute block
// Dispatch queue, integer unit, mul/div unit and commit arbiter

`timescale 1ns/10ps
`include "alu_config.svh"

module alu_unit import alu_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  logic [`ALU_UUID_BITS-1:0] issue_uuid,
    input  logic [`ALU_WID_BITS-1:0]  issue_wid,
    input  alu_op_e                   issue_op,
    input  logic [`ALU_XLEN-1:0]      issue_pc,
    input  logic [`ALU_XLEN-1:0]      issue_rs1,
    input  logic [`ALU_XLEN-1:0]      issue_rs2,
    input  logic [`ALU_XLEN-1:0]      issue_imm,
    input  logic [4:0]                issue_rd,
    input  logic                      issue_wb,
    output logic                      issue_credit,
    input  logic                      commit_credit,
    output logic                      commit_valid,
    output logic [`ALU_UUID_BITS-1:0] commit_uuid,
    output logic [`ALU_WID_BITS-1:0]  commit_wid,
    output logic [4:0]                commit_rd,
    output logic                      commit_wb,
    output logic [`ALU_XLEN-1:0]      commit_data,
    output logic                      branch_valid,
    output logic [`ALU_WID_BITS-1:0]  branch_wid,
    output logic                      branch_taken,
    output logic [`ALU_XLEN-1:0]      branch_target
);

    execute_t issue_data;
    commit_t  commit_out;

    execute_if int_exec ();
    execute_if mdv_exec ();
    commit_if  int_commit ();
    commit_if  mdv_commit ();

    assign issue_data = '{uuid: issue_uuid, wid: issue_wid, op: issue_op, pc: issue_pc,
                          rs1_data: issue_rs1, rs2_data: issue_rs2, imm: issue_imm,
                          rd: issue_rd, wb: issue_wb};

    dispatch_queue u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_data   (issue_data),
        .issue_credit (issue_credit),
        .int_if       (int_exec),
        .mdv_if       (mdv_exec)
    );

    int_unit u_int (
        .clk           (clk),
        .reset         (reset),
        .execute       (int_exec),
        .commit        (int_commit),
        .branch_valid  (branch_valid),
        .branch_wid    (branch_wid),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    muldiv_unit u_muldiv (
        .clk     (clk),
        .reset   (reset),
        .execute (mdv_exec),
        .commit  (mdv_commit)
    );

    commit_arb u_arb (
        .clk           (clk),
        .reset         (reset),
        .int_in        (int_commit),
        .mdv_in        (mdv_commit),
        .commit_credit (commit_credit),
        .commit_valid  (commit_valid),
        .commit_data   (commit_out)
    );

    assign commit_uuid = commit_out.uuid;
    assign commit_wid  = commit_out.wid;
    assign commit_rd   = commit_out.rd;
    assign commit_wb   = commit_out.wb;
    assign commit_data = commit_out.data;

endmodule

/* verification/alu_unit_properties.sv */
// Concurrent assertions on the credit and handshake rules of the ALU execute block
// Bound to alu_unit at the end of this file

`timescale 1ns/10ps
`include "alu_config.svh"

module alu_unit_properties (
    input logic clk,
    input logic reset,
    input logic issue_valid,
    input logic issue_credit,
    input logic commit_valid,
    input logic commit_credit,
    input logic branch_valid
);

    int issue_held;
    int commit_held;

    // Credits held by the issue source and by the commit arbiter
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_held  <= `ALU_QUEUE_DEPTH;
            commit_held <= `ALU_COMMIT_CREDITS;
        end else begin
            issue_held  <= issue_held + int'(issue_credit) - int'(issue_valid);
            commit_held <= commit_held + int'(commit_credit) - int'(commit_valid);
        end
    end

    issue_has_credit: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> issue_held > 0)
        else $error("issue_valid raised with no issue credit held");

    commit_has_credit: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> commit_held > 0)
        else $error("commit_valid raised beyond the returned commit credits");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !commit_valid && !branch_valid)
        else $error("commit_valid or branch_valid high right after reset");

endmodule

bind alu_unit alu_unit_properties props (
    .clk           (clk),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_credit  (issue_credit),
    .commit_valid  (commit_valid),
    .commit_credit (commit_credit),
    .branch_valid  (branch_valid)
);

/* verification/alu_unit_tb.sv */
// Testbench for the ALU execute block
// Reads the stimulus file, drives issue, returns commit credits and checks results

`timescale 1ns/10ps
`include "alu_config.svh"

module alu_unit_tb import alu_pkg::*; ();

    localparam int MAX_INSTR = 32;
    localparam int FIELDS    = 11;

    logic                      clk           = 1'b0;
    logic                      reset         = 1'b1;
    logic                      issue_valid   = 1'b0;
    logic [`ALU_UUID_BITS-1:0] issue_uuid    = '0;
    logic [`ALU_WID_BITS-1:0]  issue_wid     = '0;
    alu_op_e                   issue_op      = ADD;
    logic [`ALU_XLEN-1:0]      issue_pc      = '0;
    logic [`ALU_XLEN-1:0]      issue_rs1     = '0;
    logic [`ALU_XLEN-1:0]      issue_rs2     = '0;
    logic [`ALU_XLEN-1:0]      issue_imm     = '0;
    logic [4:0]                issue_rd      = '0;
    logic                      issue_wb      = 1'b0;
    logic                      commit_credit = 1'b0;
    logic                      issue_credit;
    logic                      commit_valid;
    logic [`ALU_UUID_BITS-1:0] commit_uuid;
    logic [`ALU_WID_BITS-1:0]  commit_wid;
    logic [4:0]                commit_rd;
    logic                      commit_wb;
    logic [`ALU_XLEN-1:0]      commit_data;
    logic                      branch_valid;
    logic [`ALU_WID_BITS-1:0]  branch_wid;
    logic                      branch_taken;
    logic [`ALU_XLEN-1:0]      branch_target;

    // Eleven words per line in the order op wid rd wb pc rs1 rs2 imm data taken target
    logic [31:0] stim_words [MAX_INSTR*FIELDS];
    bit          committed_flag [2**`ALU_UUID_BITS];
    int          branch_order [$];
    int          num_instr       = 0;
    int          issued          = 0;
    int          committed       = 0;
    int          issue_credits   = `ALU_QUEUE_DEPTH;
    int          credit_pulses   = 0;
    int          commit_held     = `ALU_COMMIT_CREDITS;
    int          pending_returns = 0;
    int          cycle_count     = 0;
    int          cycle_limit     = 0;
    int          branch_line;

    alu_unit dut (
        .clk (clk), .reset (reset),
        .issue_valid (issue_valid), .issue_uuid (issue_uuid), .issue_wid (issue_wid),
        .issue_op (issue_op), .issue_pc (issue_pc), .issue_rs1 (issue_rs1),
        .issue_rs2 (issue_rs2), .issue_imm (issue_imm), .issue_rd (issue_rd),
        .issue_wb (issue_wb), .issue_credit (issue_credit),
        .commit_credit (commit_credit), .commit_valid (commit_valid),
        .commit_uuid (commit_uuid), .commit_wid (commit_wid), .commit_rd (commit_rd),
        .commit_wb (commit_wb), .commit_data (commit_data),
        .branch_valid (branch_valid), .branch_wid (branch_wid),
        .branch_taken (branch_taken), .branch_target (branch_target)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] stim_field(input int line, input int col);
        return stim_words[line * FIELDS + col];
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else report_failure($sformatf("mismatch at %0t: %s expected %h got %h",
                                      $time, name, expected, actual));
    endtask

    // Issue one line per cycle while a queue credit is held
    always @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_credits = issue_credits + int'(issue_credit);
            credit_pulses = credit_pulses + int'(issue_credit);
            if (issued < num_instr && issue_credits > 0) begin
                issue_valid <= 1'b1;
                issue_uuid  <= `ALU_UUID_BITS'(issued);
                issue_op    <= alu_op_e'(5'(stim_field(issued, 0)));
                issue_wid   <= `ALU_WID_BITS'(stim_field(issued, 1));
                issue_rd    <= 5'(stim_field(issued, 2));
                issue_wb    <= stim_field(issued, 3) != 32'h0;
                issue_pc    <= stim_field(issued, 4);
                issue_rs1   <= stim_field(issued, 5);
                issue_rs2   <= stim_field(issued, 6);
                issue_imm   <= stim_field(issued, 7);
                issue_credits = issue_credits - 1;
                issued = issued + 1;
            end else begin
                issue_valid <= 1'b0;
            end
        end
    end

    // Results are matched by uuid and their credits go back after a random delay
    initial begin
        void'($urandom(73956));
        forever begin
            @(posedge clk);
            if (!reset) begin
                if (commit_valid) begin
                    assert (commit_held > 0)
                    else report_failure("commit_valid raised while no commit credit was held");
                    assert (int'(commit_uuid) < num_instr)
                    else report_failure("a result arrived with a uuid that was never issued");
                    assert (!committed_flag[commit_uuid])
                    else report_failure("a uuid committed more than once");
                    check_value("commit_data", stim_field(int'(commit_uuid), 8), commit_data);
                    check_value("commit_wid", stim_field(int'(commit_uuid), 1),
                                32'(commit_wid));
                    check_value("commit_rd", stim_field(int'(commit_uuid), 2),
                                32'(commit_rd));
                    check_value("commit_wb", stim_field(int'(commit_uuid), 3),
                                32'(commit_wb));
                    committed_flag[commit_uuid] = 1'b1;
                    committed = committed + 1;
                    pending_returns = pending_returns + 1;
                end
                commit_held = commit_held + int'(commit_credit) - int'(commit_valid);
                if (pending_returns > 0 && ($urandom % 4) == 0) begin
                    commit_credit <= 1'b1;
                    pending_returns = pending_returns - 1;
                end else begin
                    commit_credit <= 1'b0;
                end
            end
        end
    end

    // The integer unit is in order, so branches resolve in file order
    always @(posedge clk) begin
        if (!reset && branch_valid) begin
            assert (branch_order.size() > 0)
            else report_failure("branch_valid raised with no branch outstanding");
            branch_line = branch_order.pop_front();
            check_value("branch_wid", stim_field(branch_line, 1), 32'(branch_wid));
            check_value("branch_taken", stim_field(branch_line, 9), 32'(branch_taken));
            check_value("branch_target", stim_field(branch_line, 10), branch_target);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        assert (cycle_count <= cycle_limit)
        else report_failure("timeout while waiting for every uuid to commit");
    end

    initial begin
        for (int i = 0; i < MAX_INSTR * FIELDS; i++)
            stim_words[i] = 32'hdead_0000 | 32'(i);
        $readmemh("verification/alu_stimulus.txt", stim_words);
        while (num_instr < MAX_INSTR && stim_field(num_instr, 0) <= 32'h10)
            num_instr++;
        assert (num_instr > 0) else report_failure("the stimulus file holds no instructions");
        for (int i = 0; i < num_instr; i++)
            if (5'(stim_field(i, 0)) inside {BEQ, BNE, BLTU})
                branch_order.push_back(i);
        cycle_limit = 100 * num_instr + 10;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (committed < num_instr || pending_returns > 0)
            @(posedge clk);
        check_value("issue_credit pulses", 32'(num_instr), 32'(credit_pulses));
        check_value("issue credits held", 32'(`ALU_QUEUE_DEPTH), 32'(issue_credits));
        assert (branch_order.size() == 0)
        else report_failure("a branch never raised branch_valid");
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* verification/alu_stimulus.txt */
// op wid rd wb pc rs1 rs2 imm, then expected data, branch taken, branch target (hex)
// Line N issues with uuid N; taken and target are zero for non-branch opcodes
00 0 01 1 00001000 00000005 00000007 00000000 0000000c 0 00000000
01 1 02 1 00001004 00000003 00000005 00000000 fffffffe 0 00000000
02 2 03 1 00001008 f0f0f0f0 ff00ff00 00000000 f000f000 0 00000000
03 3 04 1 0000100c f0f0f0f0 0f0f0000 00000000 fffff0f0 0 00000000
04 0 05 1 00001010 aaaa5555 ffff0000 00000000 55555555 0 00000000
05 1 06 1 00001014 00000001 00000024 00000000 00000010 0 00000000
06 2 07 1 00001018 80000000 0000001f 00000000 00000001 0 00000000
07 3 08 1 0000101c 80000000 00000004 00000000 f8000000 0 00000000
08 0 09 1 00001020 ffffffff 00000001 00000000 00000001 0 00000000
09 1 0a 1 00001024 ffffffff 00000001 00000000 00000000 0 00000000
0a 2 00 0 00002000 12345678 12345678 00000040 00002004 1 00002040
0b 3 00 0 00002100 00000005 00000005 00000080 00002104 0 00002104
0c 1 01 1 00002200 00000001 ffffffff fffffff0 00002204 1 000021f0
0d 0 0b 1 00001030 00012345 00001000 00000000 12345000 0 00000000
0e 1 0c 1 00001034 ffffffff ffffffff 00000000 fffffffe 0 00000000
0f 2 0d 1 00001038 00000064 00000007 00000000 0000000e 0 00000000
10 3 0e 1 0000103c 00000064 00000007 00000000 00000002 0 00000000
0f 0 0f 1 00001040 12345678 00000000 00000000 ffffffff 0 00000000
10 1 10 1 00001044 12345678 00000000 00000000 12345678 0 00000000
00 2 11 1 00001048 7fffffff 00000001 00000000 80000000 0 00000000

/* alu_unit.f */
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_ifs.sv
rtl/dispatch_queue.sv
rtl/int_unit.sv
rtl/muldiv_unit.sv
rtl/commit_arb.sv
rtl/alu_unit.sv
verification/alu_unit_properties.sv
verification/alu_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the ALU execute block testbench with Verilator and run it
# The run passes only when the testbench prints its pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f alu_unit.f --top-module alu_unit_tb -o alu_unit_sim \
    && ./obj_dir/alu_unit_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
